//--- verilog/mrd_pkg.sv
// DFT processor shared widths, length limits and twiddle scaling
`default_nettype none

package mrd_pkg;

	// ##################################################
	// Frame length
	// ##################################################

	// Width of the dftpts field on both streams
	localparam int pts_w = 12;

	// Supported lengths run from min_pts to max_pts
	localparam int min_pts = 2;
	localparam int max_pts = 5;

	// Sample index inside one frame bank
	localparam int addr_w = 3;

	// ##################################################
	// Arithmetic
	// ##################################################

	// Twiddle values are signed Q1.15, so +1.0 is 32768 and needs 17 bits
	localparam int twdl_w    = 17;
	localparam int twdl_frac = 15;

	// Sum of up to five complex products of 18 by 17 bits, with headroom
	localparam int acc_w = 40;

endpackage

`default_nettype wire

//--- verilog/mrd_frame_bank.sv
// Frame bank holding one complex frame with its length and direction
`timescale 1ns/1ps
`default_nettype none

module mrd_frame_bank
	import mrd_pkg::*;
#(
	parameter int data_w = 18
)
(
	input  wire               clk,
	input  wire               rst,
	input  wire               wr_en,
	input  wire               sop,
	input  wire               eop,
	input  wire  [data_w-1:0] wr_real,
	input  wire  [data_w-1:0] wr_imag,
	input  wire  [pts_w-1:0]  pts_in,
	input  wire               inv_in,
	input  wire  [addr_w-1:0] rd_addr,
	input  wire               release_en, // Engine has drained this frame
	output logic              full,
	output logic [pts_w-1:0]  frame_pts,
	output logic              frame_inv,
	output logic [data_w-1:0] rd_real,
	output logic [data_w-1:0] rd_imag
);

	logic [data_w-1:0] mem_real [max_pts];
	logic [data_w-1:0] mem_imag [max_pts];
	logic [addr_w-1:0] wr_ptr;
	logic [addr_w-1:0] wr_addr;
	logic [pts_w-1:0]  pts_eff;

	assign wr_addr = sop ? '0 : wr_ptr; // sop restarts the frame
	assign pts_eff = sop ? pts_in : frame_pts;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			full   <= 1'b0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_addr + 1'b1;
			if (wr_en && eop)
				full <= 1'b1;
			else if (release_en)
				full <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem_real[wr_addr] <= wr_real;
			mem_imag[wr_addr] <= wr_imag;
		end
		if (wr_en && sop)
		begin
			frame_pts <= pts_in;
			frame_inv <= inv_in;
		end
		rd_real <= mem_real[rd_addr]; // One cycle read latency
		rd_imag <= mem_imag[rd_addr];
	end

	// Frame must end where its sop said, and a full bank is never overwritten
	a_eop_pos: assert property (@(posedge clk) disable iff (rst)
		wr_en && eop |-> {{(pts_w-addr_w){1'b0}}, wr_addr} == pts_eff - 1'b1);
	a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> !full);

endmodule

`default_nettype wire

//--- verilog/mrd_twiddle_rom.sv
// Twiddle ROM giving cos and sin of 2*pi*expo/pts for lengths 2 to 5
`timescale 1ns/1ps
`default_nettype none

module mrd_twiddle_rom
	import mrd_pkg::*;
(
	input  wire         [pts_w-1:0]  pts,
	input  wire         [addr_w-1:0] expo,
	output logic signed [twdl_w-1:0] cos_val,
	output logic signed [twdl_w-1:0] sin_val
);

	// ##################################################
	// Tables, one block of N entries per length
	// ##################################################

	localparam int tab_len = 14;

	// Offsets 0 for N=2, 2 for N=3, 5 for N=4, 9 for N=5
	localparam logic signed [twdl_w-1:0] cos_tab [tab_len] = '{
		17'sd32768, -17'sd32768,                           // N = 2
		17'sd32768, -17'sd16384, -17'sd16384,              // N = 3
		17'sd32768, 17'sd0, -17'sd32768, 17'sd0,           // N = 4
		17'sd32768, 17'sd10126, -17'sd26510, -17'sd26510,
		17'sd10126                                         // N = 5
	};

	localparam logic signed [twdl_w-1:0] sin_tab [tab_len] = '{
		17'sd0, 17'sd0,
		17'sd0, 17'sd28378, -17'sd28378,
		17'sd0, 17'sd32768, 17'sd0, -17'sd32768,
		17'sd0, 17'sd31164, 17'sd19261, -17'sd19261,
		-17'sd31164
	};

	logic [3:0] base;
	logic [3:0] idx;

	always_comb
	begin
		case (pts)
			pts_w'(2): base = 4'd0;
			pts_w'(3): base = 4'd2;
			pts_w'(4): base = 4'd5;
			pts_w'(5): base = 4'd9;
			default:   base = 4'd0;
		endcase
	end

	assign idx     = base + {1'b0, expo};
	assign cos_val = cos_tab[idx];
	assign sin_val = sin_tab[idx];

endmodule

`default_nettype wire

//--- verilog/mrd_dft_engine.sv
// Direct DFT engine with complex multiply-accumulate and stalling source output
`timescale 1ns/1ps
`default_nettype none

module mrd_dft_engine
	import mrd_pkg::*;
#(
	parameter int data_w = 18
)
(
	input  wire               clk,
	input  wire               rst,
	input  wire               start,
	input  wire               bank_sel,
	input  wire  [pts_w-1:0]  pts,
	input  wire               inv,
	input  wire  [data_w-1:0] rd_real_0,
	input  wire  [data_w-1:0] rd_imag_0,
	input  wire  [data_w-1:0] rd_real_1,
	input  wire  [data_w-1:0] rd_imag_1,
	input  wire               source_ready,
	output logic [addr_w-1:0] rd_addr,
	output logic              done,
	output logic              source_valid,
	output logic              source_sop,
	output logic              source_eop,
	output logic [data_w-1:0] source_real,
	output logic [data_w-1:0] source_imag,
	output logic [pts_w-1:0]  dftpts_out
);

	localparam logic signed [acc_w-1:0] sat_hi = {{(acc_w-data_w+1){1'b0}}, {(data_w-1){1'b1}}};
	localparam logic signed [acc_w-1:0] sat_lo = {{(acc_w-data_w+1){1'b1}}, {(data_w-1){1'b0}}};

	typedef enum logic [2:0] {st_idle, st_read, st_flush1, st_flush2, st_out} state_t;

	state_t                    state;
	logic                      cur_sel;
	logic                      cur_inv;
	logic        [pts_w-1:0]   cur_pts;
	logic        [addr_w-1:0]  n;
	logic        [addr_w-1:0]  k;
	logic        [addr_w-1:0]  expo;
	logic        [addr_w-1:0]  expo_d;
	logic        [addr_w-1:0]  last_idx;
	logic        [addr_w:0]    expo_sum;
	logic        [addr_w-1:0]  expo_nxt;
	logic                      v1, v2, first1, first2;
	logic signed [twdl_w-1:0]  cos_val, sin_val;
	logic signed [acc_w-1:0]   a_ext, b_ext, c_ext, s_ext;
	logic signed [acc_w-1:0]   prod_re, prod_im, acc_re, acc_im, sum_re, sum_im;

	function automatic logic [data_w-1:0] sat(input logic signed [acc_w-1:0] v);
		if (v > sat_hi)
			sat = sat_hi[data_w-1:0];
		else if (v < sat_lo)
			sat = sat_lo[data_w-1:0];
		else
			sat = v[data_w-1:0];
	endfunction

	assign rd_addr  = n;
	assign last_idx = cur_pts[addr_w-1:0] - 1'b1;

	// Exponent n*k mod N, stepped by k each read
	assign expo_sum = {1'b0, expo} + {1'b0, k};
	assign expo_nxt = (expo_sum >= {1'b0, cur_pts[addr_w-1:0]}) ?
		expo_sum[addr_w-1:0] - cur_pts[addr_w-1:0] : expo_sum[addr_w-1:0];

	mrd_twiddle_rom i_twiddle_rom (
		.pts     (cur_pts),
		.expo    (expo_d),
		.cos_val (cos_val),
		.sin_val (sin_val)
	);

	// ##################################################
	// Multiply-accumulate pipeline
	// ##################################################

	assign a_ext = acc_w'($signed(cur_sel ? rd_real_1 : rd_real_0));
	assign b_ext = acc_w'($signed(cur_sel ? rd_imag_1 : rd_imag_0));
	assign c_ext = acc_w'(cos_val);
	assign s_ext = cur_inv ? acc_w'(sin_val) : -acc_w'(sin_val); // Conjugate for forward

	assign sum_re = (first2 ? '0 : acc_re) + prod_re;
	assign sum_im = (first2 ? '0 : acc_im) + prod_im;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			v1 <= 1'b0;
			v2 <= 1'b0;
		end
		else
		begin
			v1 <= (state == st_read);
			v2 <= v1;
		end
	end

	always_ff @(posedge clk)
	begin
		first1 <= (n == '0);
		first2 <= first1;
		if (v1)
		begin
			prod_re <= a_ext * c_ext - b_ext * s_ext;
			prod_im <= a_ext * s_ext + b_ext * c_ext;
		end
		if (v2)
		begin
			acc_re <= sum_re;
			acc_im <= sum_im;
		end
		if (state == st_flush2) // Last product lands now
		begin
			source_real <= sat(sum_re >>> twdl_frac);
			source_imag <= sat(sum_im >>> twdl_frac);
			source_sop  <= (k == '0);
			source_eop  <= (k == last_idx);
			dftpts_out  <= cur_pts;
		end
	end

	// ##################################################
	// Sequencing over n and k
	// ##################################################

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state        <= st_idle;
			cur_sel      <= 1'b0;
			cur_inv      <= 1'b0;
			cur_pts      <= pts_w'(2); // Smallest supported length
			n            <= '0;
			k            <= '0;
			expo         <= '0;
			expo_d       <= '0;
			source_valid <= 1'b0;
			done         <= 1'b0;
		end
		else
		begin
			done   <= 1'b0;
			expo_d <= expo;
			case (state)
				st_idle:
					if (start)
					begin
						cur_sel <= bank_sel;
						cur_pts <= pts;
						cur_inv <= inv;
						n       <= '0;
						k       <= '0;
						expo    <= '0;
						expo_d  <= '0;
						state   <= st_read;
					end
				st_read:
				begin
					n    <= n + 1'b1;
					expo <= expo_nxt;
					if (n == last_idx)
						state <= st_flush1;
				end
				st_flush1:
					state <= st_flush2;
				st_flush2:
				begin
					source_valid <= 1'b1;
					state        <= st_out;
				end
				st_out:
					if (source_ready)
					begin
						source_valid <= 1'b0;
						if (k == last_idx)
						begin
							done  <= 1'b1;
							state <= st_idle;
						end
						else
						begin
							k     <= k + 1'b1;
							n     <= '0;
							expo  <= '0;
							state <= st_read;
						end
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	// Twiddle lookups stay inside the table block of a supported length
	a_twdl_range: assert property (@(posedge clk) disable iff (rst)
		cur_pts >= pts_w'(min_pts) && cur_pts <= pts_w'(max_pts)
			&& {{(pts_w-addr_w){1'b0}}, expo_d} < cur_pts);

	a_hold: assert property (@(posedge clk) disable iff (rst)
		source_valid && !source_ready |=>
			source_valid && $stable(source_real) && $stable(source_imag));

endmodule

`default_nettype wire

//--- verilog/mrd_ctrl_fsm.sv
// Ping-pong control for the frame banks and the DFT engine
`timescale 1ns/1ps
`default_nettype none

module mrd_ctrl_fsm
	import mrd_pkg::*;
(
	input  wire              clk,
	input  wire              rst,
	input  wire              sink_valid,
	input  wire              full_0,
	input  wire              full_1,
	input  wire              done,
	input  wire  [pts_w-1:0] pts_0,
	input  wire  [pts_w-1:0] pts_1,
	input  wire              inv_0,
	input  wire              inv_1,
	output logic             sink_ready,
	output logic             wr_en_0,
	output logic             wr_en_1,
	output logic             release_0,
	output logic             release_1,
	output logic             start,
	output logic             bank_sel,   // Bank owned by the engine
	output logic [pts_w-1:0] eng_pts,
	output logic             eng_inv
);

	logic ready_en;
	logic fill_sel;  // Bank that is filling, or filled last
	logic proc_sel;  // Next bank for the engine
	logic eng_busy;
	logic fill_full;
	logic other_full;
	logic fill_bank;
	logic proc_full;

	// ##################################################
	// Sink side
	// ##################################################

	assign fill_full  = fill_sel ? full_1 : full_0;
	assign other_full = fill_sel ? full_0 : full_1;

	// Move on as soon as the current bank is full and the other one is free
	assign fill_bank = (fill_full && !other_full) ? ~fill_sel : fill_sel;

	assign sink_ready = ready_en && !(fill_bank ? full_1 : full_0);
	assign wr_en_0    = sink_valid && sink_ready && !fill_bank;
	assign wr_en_1    = sink_valid && sink_ready && fill_bank;

	// ##################################################
	// Engine side
	// ##################################################

	assign proc_full = proc_sel ? full_1 : full_0;
	assign release_0 = done && !bank_sel;
	assign release_1 = done && bank_sel;
	assign eng_pts   = bank_sel ? pts_1 : pts_0;
	assign eng_inv   = bank_sel ? inv_1 : inv_0;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ready_en <= 1'b0;
			fill_sel <= 1'b0;
			proc_sel <= 1'b0;
			eng_busy <= 1'b0;
			start    <= 1'b0;
			bank_sel <= 1'b0;
		end
		else
		begin
			ready_en <= 1'b1;
			fill_sel <= fill_bank;
			start    <= 1'b0;
			if (done)
				eng_busy <= 1'b0;
			else if (!eng_busy && proc_full)
			begin
				start    <= 1'b1;
				eng_busy <= 1'b1;
				bank_sel <= proc_sel;
				proc_sel <= ~proc_sel; // Frames are processed in fill order
			end
		end
	end

	// The engine only finishes a frame that it was started on
	a_done_busy: assert property (@(posedge clk) disable iff (rst)
		done |-> eng_busy);

endmodule

`default_nettype wire

//--- verilog/mrd_dft_top.sv
// DFT processor top level with two frame banks, control and DFT engine
`timescale 1ns/1ps
`default_nettype none

module mrd_dft_top
	import mrd_pkg::*;
#(
	parameter int data_w = 18
)
(
	input  wire               clk,
	input  wire               rst,

	input  wire               sink_valid,
	output logic              sink_ready,
	input  wire               sink_sop,
	input  wire               sink_eop,
	input  wire  [data_w-1:0] sink_real,
	input  wire  [data_w-1:0] sink_imag,
	input  wire  [pts_w-1:0]  dftpts_in,
	input  wire               inverse,

	output logic              source_valid,
	input  wire               source_ready,
	output logic              source_sop,
	output logic              source_eop,
	output logic [data_w-1:0] source_real,
	output logic [data_w-1:0] source_imag,
	output logic [pts_w-1:0]  dftpts_out
);

	logic              wr_en_0, wr_en_1;
	logic              release_0, release_1;
	logic              full_0, full_1;
	logic [pts_w-1:0]  pts_0, pts_1, eng_pts;
	logic              inv_0, inv_1, eng_inv;
	logic [data_w-1:0] rd_real_0, rd_imag_0, rd_real_1, rd_imag_1;
	logic [addr_w-1:0] rd_addr;
	logic              start, done, bank_sel;

	// ##################################################
	// Frame banks
	// ##################################################

	mrd_frame_bank #(.data_w(data_w)) i_bank_0 (
		.clk        (clk),
		.rst        (rst),
		.wr_en      (wr_en_0),
		.sop        (sink_sop),
		.eop        (sink_eop),
		.wr_real    (sink_real),
		.wr_imag    (sink_imag),
		.pts_in     (dftpts_in),
		.inv_in     (inverse),
		.rd_addr    (rd_addr),
		.release_en (release_0),
		.full       (full_0),
		.frame_pts  (pts_0),
		.frame_inv  (inv_0),
		.rd_real    (rd_real_0),
		.rd_imag    (rd_imag_0)
	);

	mrd_frame_bank #(.data_w(data_w)) i_bank_1 (
		.clk        (clk),
		.rst        (rst),
		.wr_en      (wr_en_1),
		.sop        (sink_sop),
		.eop        (sink_eop),
		.wr_real    (sink_real),
		.wr_imag    (sink_imag),
		.pts_in     (dftpts_in),
		.inv_in     (inverse),
		.rd_addr    (rd_addr),
		.release_en (release_1),
		.full       (full_1),
		.frame_pts  (pts_1),
		.frame_inv  (inv_1),
		.rd_real    (rd_real_1),
		.rd_imag    (rd_imag_1)
	);

	// ##################################################
	// Engine and control
	// ##################################################

	mrd_dft_engine #(.data_w(data_w)) i_engine (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.bank_sel     (bank_sel),
		.pts          (eng_pts),
		.inv          (eng_inv),
		.rd_real_0    (rd_real_0),
		.rd_imag_0    (rd_imag_0),
		.rd_real_1    (rd_real_1),
		.rd_imag_1    (rd_imag_1),
		.source_ready (source_ready),
		.rd_addr      (rd_addr),
		.done         (done),
		.source_valid (source_valid),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.source_real  (source_real),
		.source_imag  (source_imag),
		.dftpts_out   (dftpts_out)
	);

	mrd_ctrl_fsm i_ctrl (
		.clk        (clk),
		.rst        (rst),
		.sink_valid (sink_valid),
		.full_0     (full_0),
		.full_1     (full_1),
		.done       (done),
		.pts_0      (pts_0),
		.pts_1      (pts_1),
		.inv_0      (inv_0),
		.inv_1      (inv_1),
		.sink_ready (sink_ready),
		.wr_en_0    (wr_en_0),
		.wr_en_1    (wr_en_1),
		.release_0  (release_0),
		.release_1  (release_1),
		.start      (start),
		.bank_sel   (bank_sel),
		.eng_pts    (eng_pts),
		.eng_inv    (eng_inv)
	);

endmodule

`default_nettype wire

//--- sim/tb_mrd_model.svh
// DFT reference model and test frame tables for the DFT processor testbench
`ifndef tb_mrd_model_svh
`define tb_mrd_model_svh
`default_nettype none

localparam int  num_tests  = 5;
localparam int  num_frames = 23;
localparam int  max_words  = 128;
localparam int  bp_test    = 3;  // Test that runs with source back-pressure
localparam real two_pi     = 6.283185307179586;

string test_name [num_tests] = '{"fwd_random", "inv_random", "impulse_sat",
	"backpressure", "mixed_stream"};

// ##################################################
// Frame tables, in send order
// ##################################################

localparam int frame_test [num_frames] = '{0,0,0,0, 1,1,1,1, 2,2,2, 3,3,3,3,
	4,4,4,4,4,4,4,4};
localparam int frame_pts [num_frames]  = '{2,3,4,5, 2,3,4,5, 4,5,4, 5,3,4,2,
	5,2,4,3,3,5,2,4};
localparam bit frame_inv [num_frames]  = '{0,0,0,0, 1,1,1,1, 0,0,1, 0,1,0,0,
	0,1,0,1,0,1,1,0};
// Kind 0 random, 1 impulse, 2 positive full scale, 3 negative full scale
localparam int frame_kind [num_frames] = '{0,0,0,0, 0,0,0,0, 1,2,3, 0,0,0,0,
	0,0,0,0,0,0,0,0};

int in_re [max_words];
int in_im [max_words];
int exp_re_tab [max_words];
int exp_im_tab [max_words];
int exp_mark_tab [max_words];  // 2 for sop, 1 for eop
int exp_pts_tab [max_words];
int word_test_tab [max_words];
int test_end [num_tests];      // Word count once the test is complete
int total_words;

// Q1.15 twiddle, rounded to nearest
function automatic int twiddle(input int e, input int pts, input bit sine);
	real ang;
	ang = two_pi * real'(e) / real'(pts);
	if (sine)
		return int'(32768.0 * $sin(ang));
	return int'(32768.0 * $cos(ang));
endfunction

function automatic int floor_sat(input longint sum);
	longint q;
	q = sum >>> twdl_frac;  // Floor, not round
	if (q > data_max)
		return data_max;
	if (q < data_min)
		return data_min;
	return int'(q);
endfunction

task automatic build_frames();
	int f, n, k, w, pts, a, b, c, s;
	longint sum_re, sum_im;
	w = 0;
	for (f = 0; f < num_frames; f++)
	begin
		pts = frame_pts[f];
		for (n = 0; n < pts; n++)
		begin
			case (frame_kind[f])
				0:
				begin
					in_re[w + n] = $random(seed) % (data_max + 1);
					in_im[w + n] = $random(seed) % (data_max + 1);
				end
				1:
				begin
					in_re[w + n] = (n == 0) ? 32767 : 0;
					in_im[w + n] = 0;
				end
				default:
				begin
					in_re[w + n] = (frame_kind[f] == 2) ? data_max : data_min;
					in_im[w + n] = in_re[w + n];
				end
			endcase
		end
		for (k = 0; k < pts; k++)
		begin
			sum_re = 0;
			sum_im = 0;
			for (n = 0; n < pts; n++)
			begin
				c = twiddle(n * k % pts, pts, 1'b0);
				s = twiddle(n * k % pts, pts, 1'b1);
				a = in_re[w + n];
				b = in_im[w + n];
				if (frame_inv[f])  // Plus j*sin, no 1/N
				begin
					sum_re += longint'(a) * c - longint'(b) * s;
					sum_im += longint'(a) * s + longint'(b) * c;
				end
				else
				begin
					sum_re += longint'(a) * c + longint'(b) * s;
					sum_im += longint'(b) * c - longint'(a) * s;
				end
			end
			exp_re_tab[w + k]    = floor_sat(sum_re);
			exp_im_tab[w + k]    = floor_sat(sum_im);
			exp_mark_tab[w + k]  = ((k == 0) ? 2 : 0) + ((k == pts - 1) ? 1 : 0);
			exp_pts_tab[w + k]   = pts;
			word_test_tab[w + k] = frame_test[f];
		end
		w += pts;
		test_end[frame_test[f]] = w;
	end
	total_words = w;
endtask

`default_nettype wire
`endif

//--- sim/tb_mrd_dft.sv
// Testbench for the DFT processor, checking every source word against a model
`timescale 1ns/1ps
`default_nettype none

module tb_mrd_dft
	import mrd_pkg::*;
();

	localparam int data_w   = 18;
	localparam int data_max = (1 << (data_w - 1)) - 1;
	localparam int data_min = -(1 << (data_w - 1));

	integer seed = 32'h0aa1_0dd2;

	`include "tb_mrd_model.svh"

	logic              clk, rst;
	logic              sink_valid, sink_sop, sink_eop, inverse, source_ready;
	logic [data_w-1:0] sink_real, sink_imag;
	logic [pts_w-1:0]  dftpts_in;
	logic              sink_ready, source_valid, source_sop, source_eop;
	logic [data_w-1:0] source_real, source_imag;
	logic [pts_w-1:0]  dftpts_out;

	int out_cnt;  // Source words accepted
	int pending;  // Complete frames not yet drained
	int cycles;
	int cycle_limit;
	int errors;
	int test_errors [num_tests];
	int tests_done;
	int tests_failed;
	bit checks_on;
	int exp_re, exp_im, exp_mark, exp_pts, cur_test;
	int act_re, act_im, act_mark, act_pts;

	assign exp_re   = exp_re_tab[out_cnt];
	assign exp_im   = exp_im_tab[out_cnt];
	assign exp_mark = exp_mark_tab[out_cnt];
	assign exp_pts  = exp_pts_tab[out_cnt];
	assign cur_test = word_test_tab[out_cnt];
	assign act_re   = int'($signed(source_real));
	assign act_im   = int'($signed(source_imag));
	assign act_mark = int'({source_sop, source_eop});
	assign act_pts  = int'(dftpts_out);

	mrd_dft_top #(.data_w(data_w)) i_mrd_dft_top (
		.clk          (clk),
		.rst          (rst),
		.sink_valid   (sink_valid),
		.sink_ready   (sink_ready),
		.sink_sop     (sink_sop),
		.sink_eop     (sink_eop),
		.sink_real    (sink_real),
		.sink_imag    (sink_imag),
		.dftpts_in    (dftpts_in),
		.inverse      (inverse),
		.source_valid (source_valid),
		.source_ready (source_ready),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.source_real  (source_real),
		.source_imag  (source_imag),
		.dftpts_out   (dftpts_out)
	);

	task automatic value_error(input string field, input int t, input int expv, input int actv);
		errors++;
		test_errors[t]++;
		$display("FAIL %s %s expected %0d actual %0d", test_name[t], field, expv, actv);
	endtask

	task automatic plain_error(input string msg);
		errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	// Holds the current beat until the DUT takes it
	task automatic wait_accept();
		bit taken;
		taken = 1'b0;
		while (!taken)
		begin
			taken = sink_ready;
			@(posedge clk);
			#2;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ##################################################
	// Checks
	// ##################################################

	a_real: assert property (@(posedge clk) disable iff (rst)
		source_valid && source_ready |-> act_re == exp_re)
		else value_error("real", $sampled(cur_test), $sampled(exp_re), $sampled(act_re));
	a_imag: assert property (@(posedge clk) disable iff (rst)
		source_valid && source_ready |-> act_im == exp_im)
		else value_error("imag", $sampled(cur_test), $sampled(exp_im), $sampled(act_im));
	a_mark: assert property (@(posedge clk) disable iff (rst)
		source_valid && source_ready |-> act_mark == exp_mark)
		else value_error("sop_eop", $sampled(cur_test), $sampled(exp_mark), $sampled(act_mark));
	a_pts: assert property (@(posedge clk) disable iff (rst)
		source_valid && source_ready |-> act_pts == exp_pts)
		else value_error("dftpts", $sampled(cur_test), $sampled(exp_pts), $sampled(act_pts));
	a_hold: assert property (@(posedge clk) disable iff (rst)
		source_valid && !source_ready |=> source_valid && $stable(source_real)
			&& $stable(source_imag) && $stable(source_sop) && $stable(source_eop))
		else plain_error("source word changed while the source was stalled");
	a_extra: assert property (@(posedge clk) disable iff (rst)
		source_valid |-> out_cnt < total_words)
		else plain_error("source produced more words than were sent");
	// Full flags clear one cycle after the last word leaves
	a_ready: assert property (@(posedge clk) disable iff (!checks_on)
		!sink_ready |-> pending >= 2 || $past(pending) >= 2)
		else plain_error("sink_ready went low while a bank was free");

	always @(posedge clk)
	begin
		if (rst)
		begin
			out_cnt <= 0;
			pending <= 0;
			cycles  <= 0;
		end
		else
		begin
			cycles <= cycles + 1;
			if (source_valid && source_ready)
				out_cnt <= out_cnt + 1;
			pending <= pending + ((sink_valid && sink_ready && sink_eop) ? 1 : 0)
				- ((source_valid && source_ready && source_eop) ? 1 : 0);
		end
	end

	always @(posedge clk)
	begin
		#2;
		if (!rst && word_test_tab[out_cnt] == bp_test)
			source_ready = (($random(seed) & 3) != 0);
		else
			source_ready = 1'b1;
	end

	// Runs half a cycle late so that assertion errors of the last word are counted
	always @(negedge clk)
	begin
		if (tests_done < num_tests && out_cnt >= test_end[tests_done])
		begin
			if (test_errors[tests_done] == 0)
				$display("test %s: ok", test_name[tests_done]);
			else
			begin
				$display("test %s: %0d mismatches", test_name[tests_done],
					test_errors[tests_done]);
				tests_failed++;
			end
			tests_done++;
		end
		if (cycles >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, %0d of %0d source words received",
				cycles, out_cnt, total_words);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ##################################################
	// Stimulus
	// ##################################################

	initial
	begin
		int f, n, w, prior;
		rst          = 1'b1;
		sink_valid   = 1'b0;
		sink_sop     = 1'b0;
		sink_eop     = 1'b0;
		sink_real    = '0;
		sink_imag    = '0;
		dftpts_in    = pts_w'(2);
		inverse      = 1'b0;
		source_ready = 1'b1;
		checks_on    = 1'b0;
		build_frames();
		cycle_limit = 40 * total_words + 200;
		repeat (4) @(posedge clk);
		#2 rst = 1'b0;
		@(posedge clk);
		#2;
		prior = errors;
		a_reset: assert (sink_ready === 1'b1 && source_valid === 1'b0)
			else plain_error("sink_ready low or source_valid high after reset");
		if (errors == prior)
			$display("test reset_state: ok");
		else
		begin
			$display("test reset_state: failed");
			tests_failed++;
		end
		checks_on = 1'b1;

		w = 0;
		for (f = 0; f < num_frames; f++)
		begin
			for (n = 0; n < frame_pts[f]; n++)
			begin
				sink_valid = 1'b1;
				sink_sop   = (n == 0);
				sink_eop   = (n == frame_pts[f] - 1);
				sink_real  = data_w'(in_re[w]);
				sink_imag  = data_w'(in_im[w]);
				dftpts_in  = pts_w'(frame_pts[f]);
				inverse    = frame_inv[f];
				wait_accept();
				w++;
			end
		end
		sink_valid = 1'b0;
		sink_sop   = 1'b0;
		sink_eop   = 1'b0;

		wait (tests_done == num_tests);
		repeat (4) @(posedge clk);
		$display("%0d tests run, %0d failed, %0d errors", num_tests + 1, tests_failed, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+sim
verilog/mrd_pkg.sv
verilog/mrd_frame_bank.sv
verilog/mrd_twiddle_rom.sv
verilog/mrd_dft_engine.sv
verilog/mrd_ctrl_fsm.sv
verilog/mrd_dft_top.sv
sim/tb_mrd_dft.sv

//--- run.sh
#!/bin/sh
# Build and run the DFT processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_mrd_dft \
	-Mdir obj_dir -o tb_mrd_dft
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_mrd_dft > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^SIMULATION PASSED$" "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1
